/* Makefile */
# Verilator build and run of the I/O-page glue testbench.
# A failing run ends in $fatal, which gives a non-zero exit status.

VERILATOR ?= verilator
TOP       ?= tb_pdp_iopage
FLIST     ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* cpu_bus_port.sv */
// CPU-facing side of the I/O-page glue.
// Decodes the KW11-L and CPU control register selects, OR-merges read data
// and replies, and routes the level-6 timer request and its vector 100.
// Purely combinational.

`timescale 1ns/1ps

module cpu_bus_port (
   // data bus
   input  pdp_iopage_pkg::paddr_t adr_i,         // physical address
   input  logic                   bus_stb_i,     // I/O-page strobe
   input  pdp_iopage_pkg::word_t  ext_dat_i,     // external devices data
   input  logic                   ext_ack_i,     // external devices reply
   input  pdp_iopage_pkg::word_t  ccr_dat_i,     // control register block data
   input  logic                   ccr_ack_i,     // control register block reply
   input  pdp_iopage_pkg::word_t  csr_dat_i,     // KW11-L word
   input  logic                   csr_ack_i,     // KW11-L reply
   output logic                   kw11l_sel_o,   // KW11-L select
   output logic                   ccr_stb_o,     // control register window strobe
   output pdp_iopage_pkg::word_t  rd_dat_o,      // merged read data to CPU
   output logic                   ack_o,         // merged reply to CPU
   // interrupts
   input  logic [7:4]             irq_i,         // external requests
   input  logic                   timer_irq_i,   // KW11-L request
   output logic [7:4]             virq_o,        // requests to CPU
   input  logic [7:4]             vstb_i,        // vector strobes from CPU
   output logic                   timer_istb_o,  // level-6 strobe to KW11-L
   input  pdp_iopage_pkg::vec_t   ivec_i,        // external vector
   input  logic                   iack_i,        // external vector ack
   output pdp_iopage_pkg::vec_t   vector_o,      // vector to CPU
   output logic                   vack_o         // vector ack to CPU
);

   import pdp_iopage_pkg::*;

   logic kw11l_hit;                              // address matches 177546
   logic ccr_hit;                                // address in 177740-177777
   logic timer_vstb;                             // CPU fetching level-6 vector

   // ***********************************************************************
   // address decode
   // ***********************************************************************
   // word address only with the byte bit ignored
   assign kw11l_hit   = (adr_i[15:1] == KW11L_ADDR[15:1]);
   assign ccr_hit     = (adr_i[15:5] == CCR_WIN_HI);
   assign kw11l_sel_o = bus_stb_i & kw11l_hit;
   assign ccr_stb_o   = bus_stb_i & ccr_hit;

   // ***********************************************************************
   // read data and reply merge
   // ***********************************************************************
   always_comb begin
      rd_dat_o = ext_dat_i;                      // external bus always ORed in
      if (ccr_stb_o)
         rd_dat_o = rd_dat_o | ccr_dat_i;
      if (kw11l_sel_o)
         rd_dat_o = rd_dat_o | csr_dat_i;
   end

   assign ack_o = ext_ack_i | ccr_ack_i | csr_ack_i;

   // ***********************************************************************
   // interrupt lines and vector bus
   // ***********************************************************************
   always_comb begin
      virq_o              = irq_i;               // 7, 5, 4 pass through
      virq_o[TIMER_LEVEL] = timer_irq_i;         // level 6 owned by the timer
   end

   assign timer_vstb   = vstb_i[TIMER_LEVEL];
   assign timer_istb_o = timer_vstb;

   // timer answers its own vector fetch
   assign vector_o = timer_vstb ? TIMER_VECTOR : ivec_i;
   assign vack_o   = iack_i | timer_vstb;

endmodule

/* files.f */
pdp_iopage_pkg.sv
line_tick_gen.sv
kw11l_csr.sv
cpu_bus_port.sv
pdp_iopage_top.sv
pdp_iopage_properties.sv
tb_pdp_iopage.sv

/* kw11l_csr.sv */
// KW11-L line clock status register at 177546.
// Holds ready (bit 7) and interrupt enable (bit 6), raises the level-6
// request on a line tick and returns a one-cycle reply to each access.
// The enable LED output is active low.

`timescale 1ns/1ps

module kw11l_csr (
   input  logic                  clk_p,
   input  logic                  arst_n_i,
   input  logic                  tick_i,         // line frequency pulse
   input  logic                  sel_i,          // decoded register select
   input  logic                  we_i,           // bus write
   input  pdp_iopage_pkg::word_t wdat_i,         // bus write data
   input  logic                  istb_i,         // level-6 vector strobe
   output pdp_iopage_pkg::word_t rdat_o,         // register word
   output logic                  ack_o,          // bus reply
   output logic                  irq_o,          // level-6 request
   output logic                  led_timer_o     // lit while enabled
);

   import pdp_iopage_pkg::*;

   kw11l_csr_u csr_q;                            // ready and enable
   kw11l_csr_u wr_view;                          // write data as fields
   logic       wr_en;                            // write this cycle
   logic       ie_nxt;                           // enable after this edge
   logic       irq_q;                            // pending request
   logic       ack_q;                            // reply flop

   assign wr_view.raw = wdat_i;
   assign wr_en       = sel_i & we_i;
   assign ie_nxt      = wr_en ? wr_view.f.ie : csr_q.f.ie;

   // ***********************************************************************
   // status register and request
   // ***********************************************************************
   always_ff @(posedge clk_p or negedge arst_n_i) begin
      if (!arst_n_i) begin
         csr_q.raw <= 16'o000200;                // ready set, enable clear
         irq_q     <= 1'b0;
      end else begin
         if (wr_en) begin
            csr_q.f.rdy <= wr_view.f.rdy;        // software may clear ready
            csr_q.f.ie  <= wr_view.f.ie;
         end
         if (tick_i) begin
            csr_q.f.rdy <= 1'b1;                 // tick wins over write
            if (ie_nxt)
               irq_q <= 1'b1;                    // request only if enabled
         end
         // vector taken or enable dropped
         if (irq_q && (istb_i || !csr_q.f.ie))
            irq_q <= 1'b0;
      end
   end

   // ***********************************************************************
   // bus reply
   // ***********************************************************************
   // one cycle after select, then every other cycle while held
   always_ff @(posedge clk_p or negedge arst_n_i) begin
      if (!arst_n_i)
         ack_q <= 1'b0;
      else
         ack_q <= sel_i & ~ack_q;
   end

   assign rdat_o      = csr_q.raw;               // unused bits read zero
   assign ack_o       = ack_q;
   assign irq_o       = irq_q;
   assign led_timer_o = ~csr_q.f.ie;             // active low

endmodule

/* line_tick_gen.sv */
// Line-frequency tick for the KW11-L.
// Divides clk_p by CLK_HZ/LINE_HZ and emits a registered one-cycle pulse
// at the end of every period, first one a full period after reset.

`timescale 1ns/1ps

module line_tick_gen #(
   parameter int CLK_HZ  = pdp_iopage_pkg::DEF_CLK_HZ,
   parameter int LINE_HZ = pdp_iopage_pkg::DEF_LINE_HZ
) (
   input  logic clk_p,
   input  logic arst_n_i,
   output logic tick_o                             // one cycle per line period
);

   localparam int DIV   = CLK_HZ / LINE_HZ;        // clocks per tick
   localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
   localparam logic [CNT_W-1:0] LAST = CNT_W'(DIV - 1); // terminal count

   logic [CNT_W-1:0] cnt_q;                        // cycle counter

   always_ff @(posedge clk_p or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cnt_q  <= '0;
         tick_o <= 1'b0;
      end else if (cnt_q == LAST) begin
         cnt_q  <= '0;                             // wrap
         tick_o <= 1'b1;                           // pulse on wrap
      end else begin
         cnt_q  <= cnt_q + 1'b1;                   // count clocks
         tick_o <= 1'b0;                           // end of pulse
      end
   end

endmodule

/* pdp_iopage_pkg.sv */
// Shared definitions for the PDP-11/70 I/O-page glue.
// Bus word and address types, fixed I/O-page addresses, the timer vector
// and the bit layout of the KW11-L line clock status register.

package pdp_iopage_pkg;

   // ***********************************************************************
   // bus types
   // ***********************************************************************
   typedef logic [15:0] word_t;                    // one unibus data word
   typedef logic [21:0] paddr_t;                   // full 22-bit physical address
   typedef logic [8:0]  vec_t;                     // interrupt vector address

   // ***********************************************************************
   // I/O-page map
   // ***********************************************************************
   localparam word_t       KW11L_ADDR   = 16'o177546;     // line clock csr
   localparam logic [10:0] CCR_WIN_HI   = 11'b11111111111; // 177740-177777
   localparam vec_t        TIMER_VECTOR = 9'o100;         // line clock vector
   localparam int          TIMER_LEVEL  = 6;              // br6

   // default rates for the module parameters
   localparam int DEF_CLK_HZ  = 50000000;          // board oscillator
   localparam int DEF_LINE_HZ = 60;                // mains frequency

   // ***********************************************************************
   // KW11-L status register
   // ***********************************************************************
   typedef struct packed {
      logic [7:0] unused_hi;                       // reads as zero
      logic       rdy;                             // bit 7 set by the line tick
      logic       ie;                              // bit 6 interrupt enable
      logic [5:0] unused_lo;                       // reads as zero
   } kw11l_fields_t;

   // same 16 bits seen as a bus word or as register fields
   typedef union packed {
      word_t         raw;                          // bus view
      kw11l_fields_t f;                            // field view
   } kw11l_csr_u;

endpackage

/* pdp_iopage_properties.sv */
// Concurrent checks on the KW11-L status register.
// Bound into every kw11l_csr instance.

`timescale 1ns/1ps

module pdp_iopage_properties (
   input logic clk_p,
   input logic arst_n_i,
   input logic tick_i,                             // line tick
   input logic ack_i,                              // register reply
   input logic irq_i,                              // level-6 request
   input logic rdy_i,                              // csr bit 7
   input logic ie_i                                // csr bit 6
);

   // reply is a single cycle pulse
   ack_one_cycle: assert property (@(posedge clk_p) disable iff (!arst_n_i)
      ack_i |=> !ack_i)
      else $error("KW11-L reply held for two cycles");

   // request only ever rises with enable set
   irq_needs_ie: assert property (@(posedge clk_p) disable iff (!arst_n_i)
      $rose(irq_i) |-> ie_i)
      else $error("timer request rose with enable clear");

   ready_after_tick: assert property (@(posedge clk_p) disable iff (!arst_n_i)
      tick_i |=> rdy_i)
      else $error("ready not set after line tick");

endmodule

bind kw11l_csr pdp_iopage_properties u_props (
   .clk_p    (clk_p),
   .arst_n_i (arst_n_i),
   .tick_i   (tick_i),
   .ack_i    (ack_o),
   .irq_i    (irq_o),
   .rdy_i    (rdat_o[7]),
   .ie_i     (rdat_o[6])
);

/* pdp_iopage_top.sv */
// Top level of the I/O-page glue around the PDP-11/70 core.
// Chain is tick generator, KW11-L register, CPU bus port. Set CLK_HZ to the
// board clock and LINE_HZ to the wanted line clock rate.

`timescale 1ns/1ps

module pdp_iopage_top #(
   parameter int CLK_HZ  = pdp_iopage_pkg::DEF_CLK_HZ,
   parameter int LINE_HZ = pdp_iopage_pkg::DEF_LINE_HZ
) (
   input  logic                   clk_p,
   input  logic                   arst_n_i,
   // data bus from the CPU side
   input  pdp_iopage_pkg::paddr_t adr_i,         // physical address
   input  pdp_iopage_pkg::word_t  wdat_i,        // write data
   input  logic                   we_i,          // write enable
   input  logic                   bus_stb_i,     // I/O-page strobe
   input  pdp_iopage_pkg::word_t  ext_dat_i,     // other devices data
   input  logic                   ext_ack_i,     // other devices reply
   input  pdp_iopage_pkg::word_t  ccr_dat_i,     // control register block data
   input  logic                   ccr_ack_i,     // control register block reply
   output logic                   ccr_stb_o,     // control register window
   output pdp_iopage_pkg::word_t  rd_dat_o,      // read data to CPU
   output logic                   ack_o,         // reply to CPU
   // interrupts
   input  logic [7:4]             irq_i,
   output logic [7:4]             virq_o,
   input  logic [7:4]             vstb_i,
   input  pdp_iopage_pkg::vec_t   ivec_i,
   input  logic                   iack_i,
   output pdp_iopage_pkg::vec_t   vector_o,
   output logic                   vack_o,
   output logic                   led_timer_o    // timer enabled, active low
);

   import pdp_iopage_pkg::*;

   logic  tick;                                  // line frequency pulse
   logic  kw11l_sel;                             // decoded KW11-L select
   word_t csr_dat;                               // KW11-L word
   logic  csr_ack;                               // KW11-L reply
   logic  timer_irq;                             // level-6 request
   logic  timer_istb;                            // level-6 vector strobe

   // ***********************************************************************
   // stages
   // ***********************************************************************
   line_tick_gen #(
      .CLK_HZ  (CLK_HZ),
      .LINE_HZ (LINE_HZ)
   ) u_tick (
      .clk_p    (clk_p),
      .arst_n_i (arst_n_i),
      .tick_o   (tick)
   );

   kw11l_csr u_kw11l (
      .clk_p       (clk_p),
      .arst_n_i    (arst_n_i),
      .tick_i      (tick),
      .sel_i       (kw11l_sel),
      .we_i        (we_i),
      .wdat_i      (wdat_i),
      .istb_i      (timer_istb),
      .rdat_o      (csr_dat),
      .ack_o       (csr_ack),
      .irq_o       (timer_irq),
      .led_timer_o (led_timer_o)
   );

   cpu_bus_port u_port (
      .adr_i        (adr_i),
      .bus_stb_i    (bus_stb_i),
      .ext_dat_i    (ext_dat_i),
      .ext_ack_i    (ext_ack_i),
      .ccr_dat_i    (ccr_dat_i),
      .ccr_ack_i    (ccr_ack_i),
      .csr_dat_i    (csr_dat),
      .csr_ack_i    (csr_ack),
      .kw11l_sel_o  (kw11l_sel),
      .ccr_stb_o    (ccr_stb_o),
      .rd_dat_o     (rd_dat_o),
      .ack_o        (ack_o),
      .irq_i        (irq_i),
      .timer_irq_i  (timer_irq),
      .virq_o       (virq_o),
      .vstb_i       (vstb_i),
      .timer_istb_o (timer_istb),
      .ivec_i       (ivec_i),
      .iack_i       (iack_i),
      .vector_o     (vector_o),
      .vack_o       (vack_o)
   );

endmodule

/* tb_pdp_iopage.sv */
// Testbench for the PDP-11/70 I/O-page glue.
// Runs the KW11-L register, the timer interrupt and vector path, and a table
// of I/O-page accesses through pdp_iopage_top with a 10:1 tick ratio.

`timescale 1ns/1ps

module tb_pdp_iopage;

   import pdp_iopage_pkg::*;

   localparam int TB_CLK_HZ  = 600;
   localparam int TB_LINE_HZ = 60;
   localparam int DIV        = TB_CLK_HZ / TB_LINE_HZ;  // clocks per tick
   localparam int TBL_LEN    = 8;
   localparam int LIMIT      = TBL_LEN * 4 + 20 * DIV;  // cycle budget
   localparam paddr_t KW_ADR = 22'o17777546;

   typedef struct {
      paddr_t adr;
      logic   we;
      word_t  wdat;
      word_t  ext_dat;
      logic   ext_ack;
      word_t  ccr_dat;
      logic   ccr_ack;
      word_t  exp_dat;
      logic   exp_ack;
      logic   exp_ccr;
   } entry_t;

   logic       clk_p;
   logic       arst_n_i;
   paddr_t     adr_i;
   word_t      wdat_i;
   logic       we_i;
   logic       bus_stb_i;
   word_t      ext_dat_i;
   logic       ext_ack_i;
   word_t      ccr_dat_i;
   logic       ccr_ack_i;
   logic       ccr_stb_o;
   word_t      rd_dat_o;
   logic       ack_o;
   logic [7:4] irq_i;
   logic [7:4] virq_o;
   logic [7:4] vstb_i;
   vec_t       ivec_i;
   logic       iack_i;
   vec_t       vector_o;
   logic       vack_o;
   logic       led_timer_o;

   logic [31:0] rng;                               // xorshift state
   int          cycles;
   entry_t      tbl [TBL_LEN];
   paddr_t      tbl_adr [TBL_LEN];

   pdp_iopage_top #(
      .CLK_HZ  (TB_CLK_HZ),
      .LINE_HZ (TB_LINE_HZ)
   ) UUT (
      .clk_p       (clk_p),
      .arst_n_i    (arst_n_i),
      .adr_i       (adr_i),
      .wdat_i      (wdat_i),
      .we_i        (we_i),
      .bus_stb_i   (bus_stb_i),
      .ext_dat_i   (ext_dat_i),
      .ext_ack_i   (ext_ack_i),
      .ccr_dat_i   (ccr_dat_i),
      .ccr_ack_i   (ccr_ack_i),
      .ccr_stb_o   (ccr_stb_o),
      .rd_dat_o    (rd_dat_o),
      .ack_o       (ack_o),
      .irq_i       (irq_i),
      .virq_o      (virq_o),
      .vstb_i      (vstb_i),
      .ivec_i      (ivec_i),
      .iack_i      (iack_i),
      .vector_o    (vector_o),
      .vack_o      (vack_o),
      .led_timer_o (led_timer_o)
   );

   // ************************************************************************
   // clock and cycle limit
   // ************************************************************************
   initial begin
      clk_p = 1'b0;
      forever #5 clk_p = ~clk_p;                   // 10 ns period
   end

   initial begin
      cycles = 0;
      forever begin
         @(posedge clk_p);
         cycles++;
         if (cycles > LIMIT) begin
            $display("=== FAIL ===");
            $fatal(1, "run did not finish within %0d cycles", LIMIT);
         end
      end
   end

   // ************************************************************************
   // helpers
   // ************************************************************************
   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic word_t rand_word();
      rng = xorshift(rng);
      return rng[15:0];
   endfunction

   task automatic check_word(input word_t got, input word_t exp, input string what);
      if (got !== exp) begin
         $display("Fail %0t: %s read %o, expected %o", $time, what, got, exp);
         $display("=== FAIL ===");
         $fatal(1, "wrong data word");
      end
   endtask

   task automatic check_vec(input vec_t got, input vec_t exp, input string what);
      if (got !== exp) begin
         $display("Fail %0t: %s is %o, expected %o", $time, what, got, exp);
         $display("=== FAIL ===");
         $fatal(1, "wrong vector");
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
         $display("=== FAIL ===");
         $fatal(1, "wrong control bit");
      end
   endtask

   // one KW11-L access with its reply one cycle after the strobe
   task automatic kw_access(input logic we, input word_t wdat, output word_t rdat);
      int n;
      @(negedge clk_p);
      adr_i     = KW_ADR;
      we_i      = we;
      wdat_i    = wdat;
      ext_dat_i = '0;
      ext_ack_i = 1'b0;
      ccr_ack_i = 1'b0;
      bus_stb_i = 1'b1;
      #2 check_bit(ack_o, 1'b0, "reply before clock edge");
      n = 0;
      do begin
         @(negedge clk_p);
         n++;
      end while (!ack_o && n < 8);
      check_bit(ack_o, 1'b1, "KW11-L reply");
      check_bit(n == 1, 1'b1, "reply one cycle after strobe");
      rdat      = rd_dat_o;
      bus_stb_i = 1'b0;                            // CPU drops strobe on reply
      we_i      = 1'b0;
   endtask

   // returns at the falling edge while the line tick is high
   task automatic sync_to_tick();
      int n;
      n = 0;
      do begin
         @(negedge clk_p);
         n++;
      end while (UUT.u_tick.tick_o !== 1'b1 && n < DIV + 2);
      if (UUT.u_tick.tick_o !== 1'b1) begin
         $display("=== FAIL ===");
         $fatal(1, "line tick did not appear within one period");
      end
   endtask

   // ************************************************************************
   // stimulus
   // ************************************************************************
   initial begin
      word_t rd;
      word_t w;
      vec_t  v;
      int    n;

      arst_n_i  = 1'b0;
      adr_i     = '0;
      wdat_i    = '0;
      we_i      = 1'b0;
      bus_stb_i = 1'b0;
      ext_dat_i = '0;
      ext_ack_i = 1'b0;
      ccr_dat_i = '0;
      ccr_ack_i = 1'b0;
      irq_i     = '0;
      vstb_i    = '0;
      ivec_i    = '0;
      iack_i    = 1'b0;
      rng       = 32'hae14;

      repeat (8) @(posedge clk_p);
      @(negedge clk_p);
      arst_n_i = 1'b1;

      // reset state
      kw_access(1'b0, '0, rd);
      check_word(rd, 16'o000200, "csr after reset");
      check_bit(led_timer_o, 1'b1, "timer led after reset");

      // write and read back where only ready and enable stick
      repeat (2) begin
         w = rand_word();
         sync_to_tick();                           // keep the tick away
         @(negedge clk_p);
         kw_access(1'b1, w, rd);
         kw_access(1'b0, '0, rd);
         check_word(rd, w & 16'o000300, "csr readback");
         check_bit(led_timer_o, ~w[6], "timer led");
      end

      // set enable with ready cleared and wait for the request
      kw_access(1'b1, 16'o000000, rd);
      kw_access(1'b1, 16'o000100, rd);
      n = 0;
      while (!virq_o[6] && n < DIV + 3) begin
         @(negedge clk_p);
         n++;
      end
      check_bit(virq_o[6], 1'b1, "timer request");
      kw_access(1'b0, '0, rd);
      check_word(rd, 16'o000300, "csr after tick");

      // level 6 vector fetch belongs to the timer
      @(negedge clk_p);
      ivec_i = rand_word() & 16'h01ff ? 9'(rng[8:0]) : 9'o004;
      iack_i = 1'b0;
      vstb_i = 4'b0100;
      #2;
      check_vec(vector_o, 9'o100, "timer vector");
      check_bit(vack_o, 1'b1, "timer vector ack");
      @(negedge clk_p);
      check_bit(virq_o[6], 1'b0, "request after vector fetch");

      // other levels pass through
      for (int i = 0; i < 2; i++) begin
         w      = rand_word();
         v      = vec_t'(w[8:0]);
         ivec_i = v;
         iack_i = w[9];
         irq_i  = w[13:10];
         vstb_i = 4'b0010;                         // level 5
         #2;
         check_vec(vector_o, v, "external vector");
         check_bit(vack_o, w[9], "external vector ack");
         check_bit(virq_o[7], w[13], "level 7 request");
         check_bit(virq_o[5], w[11], "level 5 request");
         check_bit(virq_o[4], w[10], "level 4 request");
         @(negedge clk_p);
      end
      vstb_i = '0;
      irq_i  = '0;
      iack_i = 1'b0;

      // with enable clear ready still sets but no request comes
      kw_access(1'b1, 16'o000000, rd);
      @(negedge clk_p);                            // enable now clear
      repeat (DIV + 3) begin
         @(negedge clk_p);
         check_bit(virq_o[6], 1'b0, "request with enable clear");
      end
      kw_access(1'b0, '0, rd);
      check_word(rd, 16'o000200, "ready with enable clear");

      // ***********************************************************************
      // I/O-page table
      // ***********************************************************************
      tbl_adr = '{22'o17777740, 22'o17777777, 22'o17777760, 22'o00177750,
                  22'o17777736, 22'o17776000, 22'o00001000, 22'o17777550};
      for (int i = 0; i < TBL_LEN; i++) begin
         tbl[i].adr     = tbl_adr[i];
         tbl[i].we      = i[0];
         tbl[i].wdat    = rand_word();
         tbl[i].ext_dat = rand_word();
         tbl[i].ext_ack = i[1];
         tbl[i].ccr_dat = rand_word();
         tbl[i].exp_ccr = (tbl_adr[i][15:0] >= 16'o177740);
         tbl[i].ccr_ack = tbl[i].exp_ccr;           // block answers its window only
         tbl[i].exp_dat = tbl[i].ext_dat | (tbl[i].exp_ccr ? tbl[i].ccr_dat : 16'h0);
         tbl[i].exp_ack = tbl[i].ext_ack | tbl[i].ccr_ack;
      end

      for (int i = 0; i < TBL_LEN; i++) begin
         @(negedge clk_p);
         adr_i     = tbl[i].adr;
         we_i      = tbl[i].we;
         wdat_i    = tbl[i].wdat;
         ext_dat_i = tbl[i].ext_dat;
         ext_ack_i = tbl[i].ext_ack;
         ccr_dat_i = tbl[i].ccr_dat;
         ccr_ack_i = tbl[i].ccr_ack;
         bus_stb_i = 1'b1;
         #2;
         check_bit(ccr_stb_o, tbl[i].exp_ccr, "ccr window strobe");
         check_word(rd_dat_o, tbl[i].exp_dat, "merged read data");
         check_bit(ack_o, tbl[i].exp_ack, "merged reply");
      end
      @(negedge clk_p);
      bus_stb_i = 1'b0;
      ext_ack_i = 1'b0;
      ccr_ack_i = 1'b0;
      we_i      = 1'b0;
      @(negedge clk_p);

      $display("=== PASS ===");
      $finish;
   end

endmodule
